/* Makefile */
VERILATOR ?= verilator
TOP       := tb_uart
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) -Mdir $(OBJ_DIR)
LINTFLAGS := --lint-only -Wall --timing --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* tb_uart.sv */
// uart testbench with wishbone bus tasks, serial frame driver and monitor, and checks from a case file
`timescale 1ns/100ps

module tb_uart
    import uart_pkg::*;
    import wb_pkg::*;
();

    localparam uart_div_t CLK_DIV    = 8'd2;
    localparam uart_div_t OVERSAMPLE = 8'd8;
    localparam int        BIT_CLKS   = int'(CLK_DIV) * int'(OVERSAMPLE);  // clocks per bit
    localparam int        CASE_CLKS  = 400;         // cycle budget per case

    typedef struct packed {
        logic [7:0] kind;                           // ascii T, R, E or O
        logic [1:0] count;                          // bytes used by the case
        uart_byte_t b0;
        uart_byte_t b1;
        wb_data_t   flags;                          // status expected at the check point
    } case_t;

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        rx_line;                           // tb to dut serial
    logic        tx_line;                           // dut to tb serial
    case_t       cases[$];
    int unsigned cycle_cnt  = 0;
    int unsigned max_cycles = 0;
    logic [31:0] rng_state;

    uart_top #(.CLK_DIV(CLK_DIV), .OVERSAMPLE(OVERSAMPLE)) dut_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp),
        .uart_rx (rx_line),
        .uart_tx (tx_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    // ----------------------------------------
    // failure handling and checks
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string what, input uart_byte_t got, input uart_byte_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_status(input string what, input wb_data_t got, input wb_data_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0d ns: %s is %h, expected %h",
                                $time, what, got, exp));
    endtask

    task automatic check_line(input string what, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error at %0d ns: %s is %b, expected %b",
                                $time, what, got, exp));
    endtask

    // watchdog started once the case count sets the limit
    initial begin
        wait (max_cycles != 0);
        while (cycle_cnt < max_cycles) begin
            @(posedge clk);
            cycle_cnt++;
        end
        abort_run($sformatf("timeout: no end of test after %0d cycles", cycle_cnt));
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ----------------------------------------
    // wishbone master
    // ----------------------------------------
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                             output wb_data_t rdat);
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_rsp.ack)
            @(negedge clk);                         // stretched by tx back-pressure
        rdat   = wb_rsp.dat;
        wb_req = '0;                                // drop cyc and stb after ack
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
        bus_cycle(1'b0, adr, '0, dat);
    endtask

    // poll status until one bit reaches the wanted level
    task automatic wait_status(input int pos, input logic level, output wb_data_t st);
        wb_read(REG_STATUS, st);
        while (st[pos] !== level)
            wb_read(REG_STATUS, st);
    endtask

    // ----------------------------------------
    // serial side
    // ----------------------------------------
    task automatic send_frame(input uart_byte_t b, input logic stop);
        @(negedge clk);
        rx_line = 1'b0;                             // start bit
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            rx_line = b[i];                         // lsb first
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx_line = stop;
        repeat (BIT_CLKS) @(negedge clk);
        rx_line = 1'b1;                             // back to idle
    endtask

    task automatic receive_frame(output uart_byte_t b);
        @(negedge tx_line);
        repeat (BIT_CLKS / 2) @(negedge clk);       // mid start bit
        check_line("uart_tx start bit at mid-bit", tx_line, 1'b0);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = tx_line;
        end
        repeat (BIT_CLKS) @(negedge clk);
        check_line("uart_tx stop bit at mid-bit", tx_line, 1'b1);
    endtask

    // ----------------------------------------
    // case runners
    // ----------------------------------------
    task automatic run_tx_case(input case_t c);
        wb_data_t   st;
        uart_byte_t got;
        logic       first_done;
        first_done = 1'b0;
        fork
            begin
                wb_write(REG_DATA, c.b0);
                wb_read(REG_STATUS, st);
                check_status("status during tx frame", st, c.flags);
                if (c.count == 2'd2) begin
                    wb_write(REG_DATA, c.b1);       // ack held off while busy
                    if (!first_done)
                        abort_run("second tx write acknowledged before first frame ended");
                end
            end
            begin
                receive_frame(got);
                check_byte("first tx frame", got, c.b0);
                first_done = 1'b1;
                if (c.count == 2'd2) begin
                    receive_frame(got);
                    check_byte("second tx frame", got, c.b1);
                end
            end
        join
        wait_status(STAT_TX_BUSY, 1'b0, st);
        check_status("status after tx", st, '0);
    endtask

    task automatic run_rx_case(input case_t c);
        wb_data_t st;
        wb_data_t d;
        send_frame(c.b0, c.kind != "E");            // E has a low stop bit
        if (c.kind == "O")
            send_frame(c.b1, 1'b1);                 // no read in between
        wait_status(c.kind == "E" ? STAT_RX_ERROR : STAT_RX_VALID, 1'b1, st);
        check_status("status after rx", st, c.flags);
        if (c.kind != "E") begin
            wb_read(REG_DATA, d);
            check_byte("rx data", d, c.kind == "O" ? c.b1 : c.b0);
        end
        wb_read(REG_STATUS, st);
        check_status("status after clear", st, '0);
    endtask

    task automatic read_cases();
        int         fd;
        int         n;
        int         cnt;
        string      line;
        logic [7:0] kind;
        uart_byte_t b0;
        uart_byte_t b1;
        wb_data_t   fl;
        case_t      entry;
        fd = $fopen("uart_cases.txt", "r");
        if (fd == 0)
            abort_run("could not open uart_cases.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%c %d %h %h %h", kind, cnt, b0, b1, fl);
            if (n == 5) begin                       // comment lines fall out here
                entry = '{kind: kind, count: 2'(cnt), b0: b0, b1: b1, flags: fl};
                cases.push_back(entry);
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        wb_data_t st;
        rst_n     = 1'b0;
        wb_req    = '0;
        rx_line   = 1'b1;                           // serial idle
        rng_state = 32'h6121;
        read_cases();
        if (cases.size() == 0)
            abort_run("uart_cases.txt holds no cases");
        max_cycles = cases.size() * CASE_CLKS + 1000;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_line("uart_tx after reset", tx_line, 1'b1);
        wb_read(REG_STATUS, st);
        check_status("status after reset", st, '0);

        foreach (cases[i]) begin
            rng_state = xorshift(rng_state);
            repeat (rng_state[4:0]) @(negedge clk);  // random idle gap
            $display("case %0d: kind %s bytes %h %h", i, cases[i].kind,
                     cases[i].b0, cases[i].b1);
            case (cases[i].kind)
                "T":           run_tx_case(cases[i]);
                "R", "E", "O": run_rx_case(cases[i]);
                default:       abort_run($sformatf("case %0d has unknown kind", i));
            endcase
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

/* uart_baud_gen.sv */
// uart prescaler producing a one-clock oversample tick every CLK_DIV clocks
`timescale 1ns/100ps

module uart_baud_gen
    import uart_pkg::*;
#(
    parameter uart_div_t CLK_DIV = 8'd2         // clocks per oversample tick
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick                           // one-clock pulse
);

    localparam uart_div_t RELOAD = CLK_DIV - 8'd1;

    uart_div_t cnt_q;                           // down-counter

    // free-running from reset, tick on each reload
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= RELOAD;
            tick  <= 1'b0;
        end else begin
            if (cnt_q == '0) begin
                cnt_q <= RELOAD;                // wrap
                tick  <= 1'b1;
            end else begin
                cnt_q <= cnt_q - 8'd1;
                tick  <= 1'b0;
            end
        end
    end

endmodule

/* uart_cases.txt */
# kind count byte0 byte1 status, hex bytes, byte1 only used when count is 2
# T status read during the frame, R/E/O status read when the flag is first seen
T 1 a5 00 01
T 1 00 00 01
T 1 ff 00 01
T 1 81 00 01
T 2 3c c3 01
T 2 55 aa 01
R 1 5a 00 02
R 1 00 00 02
R 1 ff 00 02
R 1 81 00 02
E 1 e7 00 04
E 1 00 00 04
R 1 c6 00 02
O 2 12 34 0a
O 2 fe 01 0a
T 1 7e 00 01
R 1 3d 00 02
E 1 ff 00 04

/* uart_pkg.sv */
// uart serial-side package: byte and divider types, rx event bundle, fsm states
package uart_pkg;

    // ----------------------------------------
    // frame format
    // ----------------------------------------
    localparam int UART_DATA_BITS = 8;          // data bits per frame, lsb first

    typedef logic [7:0] uart_byte_t;            // one byte on the serial link
    typedef logic [7:0] uart_div_t;             // prescaler / oversample counters

    // receiver to register block, ten bits
    typedef struct packed {
        logic       done;                       // one-cycle strobe at stop sample
        logic       error;                      // stop bit sampled low
        uart_byte_t data;                       // received byte
    } uart_rx_evt_t;

    // ----------------------------------------
    // state machines
    // ----------------------------------------
    typedef enum logic [1:0] {
        RX_IDLE,                                // hunting for falling edge
        RX_START,                               // waiting for mid start bit
        RX_DATA,                                // shifting data bits
        RX_STOP                                 // waiting for mid stop bit
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,                                // line high, may hold a pending byte
        TX_START,                               // driving start bit
        TX_DATA,                                // driving data bits
        TX_STOP                                 // driving stop bit
    } tx_state_t;

endpackage

/* uart_rx.sv */
// uart receiver: two-flop synchroniser, mid-bit sampling fsm, stop bit check
`timescale 1ns/100ps

module uart_rx
    import uart_pkg::*;
#(
    parameter uart_div_t OVERSAMPLE = 8'd8      // ticks per bit
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         tick,                  // oversample enable
    input  logic         uart_rx,               // async serial input
    output uart_rx_evt_t rx_evt
);

    localparam uart_div_t HALF_BIT = (OVERSAMPLE >> 1) - 8'd1;  // to mid start bit
    localparam uart_div_t FULL_BIT = OVERSAMPLE - 8'd1;         // mid to mid
    localparam logic [2:0] LAST_BIT = 3'(UART_DATA_BITS - 1);

    // ----------------------------------------
    // input synchroniser
    // ----------------------------------------
    logic rx_meta_q;
    logic rx_sync_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta_q <= 1'b1;                  // line idles high
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= uart_rx;
            rx_sync_q <= rx_meta_q;
        end
    end

    // ----------------------------------------
    // receive fsm
    // ----------------------------------------
    rx_state_t  state_q;
    uart_div_t  tick_cnt_q;                     // ticks left to next sample
    logic [2:0] bit_cnt_q;                      // data bit index
    uart_byte_t shift_q;                        // lsb arrives first
    logic       done_q;
    logic       err_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= RX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            done_q     <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;                     // strobe
            if (tick) begin
                if (state_q == RX_IDLE) begin
                    if (!rx_sync_q) begin       // falling edge seen
                        state_q    <= RX_START;
                        tick_cnt_q <= HALF_BIT;
                    end
                end else if (tick_cnt_q != '0) begin
                    tick_cnt_q <= tick_cnt_q - 8'd1;
                end else begin
                    tick_cnt_q <= FULL_BIT;     // sample point
                    case (state_q)
                        RX_START: begin
                            bit_cnt_q <= '0;
                            state_q   <= rx_sync_q ? RX_IDLE : RX_DATA;  // high means glitch
                        end
                        RX_DATA: begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == LAST_BIT)
                                state_q <= RX_STOP;
                        end
                        RX_STOP: begin
                            done_q  <= 1'b1;
                            err_q   <= !rx_sync_q;  // framing error
                            state_q <= RX_IDLE;
                        end
                        default: state_q <= RX_IDLE;
                    endcase
                end
            end
        end
    end

    // data shifter, payload only
    always_ff @(posedge clk) begin
        if (tick && state_q == RX_DATA && tick_cnt_q == '0)
            shift_q <= {rx_sync_q, shift_q[7:1]};
    end

    assign rx_evt = '{done: done_q, error: err_q, data: shift_q};

endmodule

/* uart_top.sv */
// uart top level: prescaler, receiver, transmitter and wishbone register block
`timescale 1ns/100ps

module uart_top
    import uart_pkg::*;
    import wb_pkg::*;
#(
    parameter uart_div_t CLK_DIV    = 8'd27,    // 50 MHz / 27 / 16 ~ 115.2 kbaud
    parameter uart_div_t OVERSAMPLE = 8'd16     // ticks per bit
) (
    input  logic    clk,
    input  logic    rst_n,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    input  logic    uart_rx,                    // serial in
    output logic    uart_tx                     // serial out, idle high
);

    logic         tick;
    uart_rx_evt_t rx_evt;
    logic         tx_start;
    uart_byte_t   tx_byte;
    logic         tx_busy;

    uart_baud_gen #(.CLK_DIV(CLK_DIV)) baud_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    uart_rx #(.OVERSAMPLE(OVERSAMPLE)) rx_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .tick    (tick),
        .uart_rx (uart_rx),
        .rx_evt  (rx_evt)
    );

    uart_tx #(.OVERSAMPLE(OVERSAMPLE)) tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .tx_start (tx_start),
        .tx_byte  (tx_byte),
        .tx_busy  (tx_busy),
        .uart_tx  (uart_tx)
    );

    uart_wb_regs regs_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .rx_evt   (rx_evt),
        .tx_busy  (tx_busy),
        .tx_start (tx_start),
        .tx_byte  (tx_byte)
    );

endmodule

/* uart_tx.sv */
// uart transmitter: start bit, eight data bits lsb first, stop bit, registered line
`timescale 1ns/100ps

module uart_tx
    import uart_pkg::*;
#(
    parameter uart_div_t OVERSAMPLE = 8'd8      // ticks per bit
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tick,                    // oversample enable
    input  logic       tx_start,                // one-cycle load strobe
    input  uart_byte_t tx_byte,
    output logic       tx_busy,
    output logic       uart_tx                  // high when idle
);

    localparam uart_div_t FULL_BIT = OVERSAMPLE - 8'd1;
    localparam logic [2:0] LAST_BIT = 3'(UART_DATA_BITS - 1);

    tx_state_t  state_q;
    uart_div_t  tick_cnt_q;                     // ticks left in current bit
    logic [2:0] bit_cnt_q;
    uart_byte_t shift_q;                        // next data bit at [0]

    // ----------------------------------------
    // transmit fsm
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= TX_IDLE;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx_busy    <= 1'b0;
            uart_tx    <= 1'b1;
        end else begin
            if (state_q == TX_IDLE) begin
                if (tx_start && !tx_busy)
                    tx_busy <= 1'b1;            // byte pending
                else if (tick && tx_busy) begin
                    uart_tx    <= 1'b0;         // start bit on next tick
                    tick_cnt_q <= FULL_BIT;
                    state_q    <= TX_START;
                end
            end else if (tick) begin
                if (tick_cnt_q != '0) begin
                    tick_cnt_q <= tick_cnt_q - 8'd1;
                end else begin
                    tick_cnt_q <= FULL_BIT;     // bit boundary
                    case (state_q)
                        TX_START: begin
                            uart_tx   <= shift_q[0];
                            bit_cnt_q <= '0;
                            state_q   <= TX_DATA;
                        end
                        TX_DATA: begin
                            bit_cnt_q <= bit_cnt_q + 3'd1;
                            if (bit_cnt_q == LAST_BIT) begin
                                uart_tx <= 1'b1;    // stop bit
                                state_q <= TX_STOP;
                            end else begin
                                uart_tx <= shift_q[0];
                            end
                        end
                        default: begin          // end of stop bit
                            tx_busy <= 1'b0;
                            state_q <= TX_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    // byte latch and shifter, payload only
    always_ff @(posedge clk) begin
        if (state_q == TX_IDLE && tx_start && !tx_busy)
            shift_q <= tx_byte;
        else if (tick && tick_cnt_q == '0 && (state_q == TX_START || state_q == TX_DATA))
            shift_q <= {1'b0, shift_q[7:1]};    // consume one bit
    end

endmodule

/* uart_wb_regs.sv */
// uart register block: wishbone classic slave, rx holding register, sticky status flags
`timescale 1ns/100ps

module uart_wb_regs
    import uart_pkg::*;
    import wb_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  wb_req_t      wb_req,
    output wb_rsp_t      wb_rsp,
    input  uart_rx_evt_t rx_evt,
    input  logic         tx_busy,
    output logic         tx_start,              // one-cycle, same cycle as ack
    output uart_byte_t   tx_byte
);

    logic       ack_q;
    wb_data_t   rd_dat_q;
    uart_byte_t rx_hold_q;                      // one-byte holding register
    logic       rx_valid_q;
    logic       rx_error_q;
    logic       rx_overrun_q;
    wb_data_t   status;

    logic req;
    logic rd_data;
    logic rd_stat;
    logic wr_data;
    logic acc_ok;

    // ----------------------------------------
    // bus decode
    // ----------------------------------------
    assign req     = wb_req.cyc && wb_req.stb && !ack_q;   // ack cycle is not a new request
    assign rd_data = req && !wb_req.we && wb_req.adr == REG_DATA;
    assign rd_stat = req && !wb_req.we && wb_req.adr == REG_STATUS;
    assign wr_data = req && wb_req.we && wb_req.adr == REG_DATA;
    assign acc_ok  = req && !(wr_data && tx_busy);  // hold off tx writes while busy

    always_comb begin
        status                  = '0;
        status[STAT_TX_BUSY]    = tx_busy;
        status[STAT_RX_VALID]   = rx_valid_q;
        status[STAT_RX_ERROR]   = rx_error_q;
        status[STAT_RX_OVERRUN] = rx_overrun_q;
    end

    // ----------------------------------------
    // ack, tx strobe, sticky flags
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q        <= 1'b0;
            tx_start     <= 1'b0;
            rx_valid_q   <= 1'b0;
            rx_error_q   <= 1'b0;
            rx_overrun_q <= 1'b0;
        end else begin
            ack_q    <= acc_ok;
            tx_start <= acc_ok && wr_data;
            if (rd_data)
                rx_valid_q <= 1'b0;             // byte taken
            if (rd_stat) begin
                rx_error_q   <= 1'b0;           // cleared after being returned
                rx_overrun_q <= 1'b0;
            end
            if (rx_evt.done) begin              // new event wins over clears
                if (rx_evt.error)
                    rx_error_q <= 1'b1;
                else begin
                    rx_valid_q <= 1'b1;
                    if (rx_valid_q && !rd_data)
                        rx_overrun_q <= 1'b1;   // previous byte lost
                end
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (acc_ok)
            rd_dat_q <= (wb_req.adr == REG_STATUS) ? status : rx_hold_q;
        if (acc_ok && wr_data)
            tx_byte <= wb_req.dat;
        if (rx_evt.done && !rx_evt.error)
            rx_hold_q <= rx_evt.data;           // overwrite on overrun
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat_q};

endmodule

/* verilog.f */
uart_pkg.sv
wb_pkg.sv
uart_baud_gen.sv
uart_rx.sv
uart_tx.sv
uart_wb_regs.sv
uart_top.sv
tb_uart.sv

/* wb_pkg.sv */
// wishbone classic slave package: bus bundles, register map, status bit layout
package wb_pkg;

    typedef logic [0:0] wb_addr_t;              // two registers only
    typedef logic [7:0] wb_data_t;              // byte-wide data bus

    // master to slave
    typedef struct packed {
        logic     cyc;                          // bus cycle in progress
        logic     stb;                          // strobe, request valid
        logic     we;                           // write enable
        wb_addr_t adr;                          // register select
        wb_data_t dat;                          // write data
    } wb_req_t;

    // slave to master
    typedef struct packed {
        logic     ack;                          // single-cycle acknowledge
        wb_data_t dat;                          // read data, valid with ack
    } wb_rsp_t;

    // ----------------------------------------
    // register map
    // ----------------------------------------
    localparam wb_addr_t REG_DATA   = 1'b0;     // rx holding / tx data
    localparam wb_addr_t REG_STATUS = 1'b1;     // flags, read clears sticky bits

    // status byte bit positions
    localparam int STAT_TX_BUSY    = 0;         // frame being sent
    localparam int STAT_RX_VALID   = 1;         // unread byte in holding reg
    localparam int STAT_RX_ERROR   = 2;         // framing error, sticky
    localparam int STAT_RX_OVERRUN = 3;         // byte lost, sticky

endpackage
